// ==== source/mmu_pkg.sv ====
package mmu_pkg;

    // address widths
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    // tlb entry fields
    typedef logic [18:0] vpn2_t;
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;

    // translation fault code
    typedef logic [1:0]  fault_t;

    localparam fault_t FAULT_NONE     = 2'd0;
    localparam fault_t FAULT_REFILL   = 2'd1;
    localparam fault_t FAULT_INVALID  = 2'd2;
    localparam fault_t FAULT_MODIFIED = 2'd3;

    // 4 KiB pages, vpn2 covers an even/odd pair
    localparam int PAGE_OFFSET_W = 12;

    // bits 31:30 of a kseg0/kseg1 style address
    localparam logic [1:0] UNMAPPED_SEG = 2'b10;

    // top bits dropped on the unmapped path
    localparam int SEG_MASK_W = 3;

    localparam int DEFAULT_TLB_ENTRIES = 16;

endpackage

// ==== source/tlb_search_if.sv ====
`timescale 1ns/10ps

interface tlb_search_if
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = DEFAULT_TLB_ENTRIES
) ();

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // request, combinational, same cycle as the result
    vpn2_t            vpn2;
    logic             odd_page;
    asid_t            asid;

    // result of the selected page half
    logic             found;
    logic [IDX_W-1:0] index;
    pfn_t             pfn;
    cattr_t           c;
    logic             d;
    logic             v;

    modport lookup (
        output vpn2, odd_page, asid,
        input  found, index, pfn, c, d, v
    );

    modport array (
        input  vpn2, odd_page, asid,
        output found, index, pfn, c, d, v
    );

endinterface

// ==== source/tlb_array.sv ====
`timescale 1ns/10ps

module tlb_array
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = DEFAULT_TLB_ENTRIES,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic             aclk,
    input  logic             rst,

    // indexed write
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_index,
    input  vpn2_t            wr_vpn2,
    input  asid_t            wr_asid,
    input  logic             wr_g,
    input  pfn_t             wr_pfn0,
    input  cattr_t           wr_c0,
    input  logic             wr_d0,
    input  logic             wr_v0,
    input  pfn_t             wr_pfn1,
    input  cattr_t           wr_c1,
    input  logic             wr_d1,
    input  logic             wr_v1,

    // indexed read, one cycle latency
    input  logic             rd_en,
    input  logic [IDX_W-1:0] rd_index,
    output logic             rd_valid,
    output vpn2_t            rd_vpn2,
    output asid_t            rd_asid,
    output logic             rd_g,
    output pfn_t             rd_pfn0,
    output cattr_t           rd_c0,
    output logic             rd_d0,
    output logic             rd_v0,
    output pfn_t             rd_pfn1,
    output cattr_t           rd_c1,
    output logic             rd_d1,
    output logic             rd_v1,

    tlb_search_if.array      search
);

    // tag part
    vpn2_t                  tag_vpn2 [TLB_ENTRIES];
    asid_t                  tag_asid [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] g_q;

    // even and odd page halves
    pfn_t                   pfn0_q [TLB_ENTRIES];
    pfn_t                   pfn1_q [TLB_ENTRIES];
    cattr_t                 c0_q   [TLB_ENTRIES];
    cattr_t                 c1_q   [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] d0_q;
    logic [TLB_ENTRIES-1:0] v0_q;
    logic [TLB_ENTRIES-1:0] d1_q;
    logic [TLB_ENTRIES-1:0] v1_q;

    logic [TLB_ENTRIES-1:0] match;
    logic [IDX_W-1:0]       hit_index;

    // tags and flags are cleared so no entry is valid after reset
    always_ff @(posedge aclk) begin
        if (rst) begin
            g_q  <= '0;
            d0_q <= '0;
            v0_q <= '0;
            d1_q <= '0;
            v1_q <= '0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                tag_vpn2[i] <= '0;
                tag_asid[i] <= '0;
            end
        end else if (wr_en) begin
            tag_vpn2[wr_index] <= wr_vpn2;
            tag_asid[wr_index] <= wr_asid;
            g_q[wr_index]      <= wr_g;
            d0_q[wr_index]     <= wr_d0;
            v0_q[wr_index]     <= wr_v0;
            d1_q[wr_index]     <= wr_d1;
            v1_q[wr_index]     <= wr_v1;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            pfn0_q[wr_index] <= wr_pfn0;
            c0_q[wr_index]   <= wr_c0;
            pfn1_q[wr_index] <= wr_pfn1;
            c1_q[wr_index]   <= wr_c1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_vpn2 <= tag_vpn2[rd_index];
            rd_asid <= tag_asid[rd_index];
            rd_g    <= g_q[rd_index];
            rd_pfn0 <= pfn0_q[rd_index];
            rd_c0   <= c0_q[rd_index];
            rd_d0   <= d0_q[rd_index];
            rd_v0   <= v0_q[rd_index];
            rd_pfn1 <= pfn1_q[rd_index];
            rd_c1   <= c1_q[rd_index];
            rd_d1   <= d1_q[rd_index];
            rd_v1   <= v1_q[rd_index];
        end
    end

    // global entries ignore the asid
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = (tag_vpn2[i] == search.vpn2) &&
                       (g_q[i] || (tag_asid[i] == search.asid));
        end
    end

    always_comb begin
        hit_index = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                hit_index = IDX_W'(i);
            end
        end
    end

    assign search.found = |match;
    assign search.index = hit_index;
    assign search.pfn   = search.odd_page ? pfn1_q[hit_index] : pfn0_q[hit_index];
    assign search.c     = search.odd_page ? c1_q[hit_index]   : c0_q[hit_index];
    assign search.d     = search.odd_page ? d1_q[hit_index]   : d0_q[hit_index];
    assign search.v     = search.odd_page ? v1_q[hit_index]   : v0_q[hit_index];

    // software must never leave two entries covering the same page
    multi_match_a: assert property (
        @(posedge aclk) disable iff (rst) $onehot0(match)
    ) else $error("tlb multiple match, vpn2 %h asid %h", search.vpn2, search.asid);

endmodule

// ==== source/tlb_lookup.sv ====
`timescale 1ns/10ps

module tlb_lookup
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = DEFAULT_TLB_ENTRIES,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic             aclk,
    input  logic             rst,

    input  logic             req_valid,
    output logic             req_ready,
    input  vaddr_t           req_vaddr,
    input  asid_t            req_asid,
    input  logic             req_store,

    output logic             rsp_valid,
    input  logic             rsp_ready,
    output paddr_t           rsp_paddr,
    output cattr_t           rsp_cattr,
    output logic [IDX_W-1:0] rsp_index,
    output fault_t           rsp_fault,

    tlb_search_if.lookup     search
);

    localparam cattr_t UNMAPPED_CATTR = cattr_t'(3);
    localparam int     VADDR_W        = $bits(vaddr_t);

    logic             active;

    // stage 1, request under search
    logic             s1_valid;
    vaddr_t           s1_vaddr;
    asid_t            s1_asid;
    logic             s1_store;

    // stage 2, finished response
    logic             s2_valid;
    logic             s2_ready;
    paddr_t           s2_paddr;
    cattr_t           s2_cattr;
    logic [IDX_W-1:0] s2_index;
    fault_t           s2_fault;

    logic             unmapped;
    paddr_t           res_paddr;
    cattr_t           res_cattr;
    logic [IDX_W-1:0] res_index;
    fault_t           res_fault;

    // stage 2 frees up in the same cycle it is consumed
    assign s2_ready  = !s2_valid || rsp_ready;
    assign req_ready = active && (!s1_valid || s2_ready);

    always_ff @(posedge aclk) begin
        if (rst) begin
            active   <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (req_ready) begin
                s1_valid <= req_valid;
            end
            if (s2_ready) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            // idle search key, no entry after reset carries this asid
            s1_asid <= '1;
        end else if (req_valid && req_ready) begin
            s1_vaddr <= req_vaddr;
            s1_asid  <= req_asid;
            s1_store <= req_store;
        end
    end

    assign search.vpn2     = s1_vaddr[VADDR_W-1 -: $bits(vpn2_t)];
    assign search.odd_page = s1_vaddr[PAGE_OFFSET_W];
    assign search.asid     = s1_asid;

    assign unmapped = (s1_vaddr[VADDR_W-1 -: 2] == UNMAPPED_SEG);

    // fault priority is refill, then invalid, then modified
    always_comb begin
        res_paddr = '0;
        res_cattr = '0;
        res_index = '0;
        res_fault = FAULT_NONE;
        if (unmapped) begin
            res_paddr = {{SEG_MASK_W{1'b0}}, s1_vaddr[VADDR_W-SEG_MASK_W-1:0]};
            res_cattr = UNMAPPED_CATTR;
        end else if (!search.found) begin
            res_fault = FAULT_REFILL;
        end else if (!search.v) begin
            res_fault = FAULT_INVALID;
        end else if (s1_store && !search.d) begin
            res_fault = FAULT_MODIFIED;
        end else begin
            res_paddr = {search.pfn, s1_vaddr[PAGE_OFFSET_W-1:0]};
            res_cattr = search.c;
            res_index = search.index;
        end
    end

    always_ff @(posedge aclk) begin
        if (s1_valid && s2_ready) begin
            s2_paddr <= res_paddr;
            s2_cattr <= res_cattr;
            s2_index <= res_index;
            s2_fault <= res_fault;
        end
    end

    assign rsp_valid = s2_valid;
    assign rsp_paddr = s2_paddr;
    assign rsp_cattr = s2_cattr;
    assign rsp_index = s2_index;
    assign rsp_fault = s2_fault;

    // a stalled response is held until the consumer takes it
    rsp_hold_a: assert property (
        @(posedge aclk) disable iff (rst)
        rsp_valid && !rsp_ready |=>
            rsp_valid && $stable({rsp_paddr, rsp_cattr, rsp_index, rsp_fault})
    ) else $error("response changed while stalled");

endmodule

// ==== source/mmu_top.sv ====
`timescale 1ns/10ps

module mmu_top
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = DEFAULT_TLB_ENTRIES,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic             aclk,
    input  logic             rst,

    // translation request
    input  logic             req_valid,
    output logic             req_ready,
    input  vaddr_t           req_vaddr,
    input  asid_t            req_asid,
    input  logic             req_store,

    // translation response
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output paddr_t           rsp_paddr,
    output cattr_t           rsp_cattr,
    output logic [IDX_W-1:0] rsp_index,
    output fault_t           rsp_fault,

    // entry write
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_index,
    input  vpn2_t            wr_vpn2,
    input  asid_t            wr_asid,
    input  logic             wr_g,
    input  pfn_t             wr_pfn0,
    input  cattr_t           wr_c0,
    input  logic             wr_d0,
    input  logic             wr_v0,
    input  pfn_t             wr_pfn1,
    input  cattr_t           wr_c1,
    input  logic             wr_d1,
    input  logic             wr_v1,

    // entry read
    input  logic             rd_en,
    input  logic [IDX_W-1:0] rd_index,
    output logic             rd_valid,
    output vpn2_t            rd_vpn2,
    output asid_t            rd_asid,
    output logic             rd_g,
    output pfn_t             rd_pfn0,
    output cattr_t           rd_c0,
    output logic             rd_d0,
    output logic             rd_v0,
    output pfn_t             rd_pfn1,
    output cattr_t           rd_c1,
    output logic             rd_d1,
    output logic             rd_v1
);

    tlb_search_if #(.TLB_ENTRIES(TLB_ENTRIES)) search_if ();

    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_lookup_i (
        .aclk      (aclk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_vaddr (req_vaddr),
        .req_asid  (req_asid),
        .req_store (req_store),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_paddr (rsp_paddr),
        .rsp_cattr (rsp_cattr),
        .rsp_index (rsp_index),
        .rsp_fault (rsp_fault),
        .search    (search_if.lookup)
    );

    tlb_array #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_array_i (
        .aclk     (aclk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_vpn2  (wr_vpn2),
        .wr_asid  (wr_asid),
        .wr_g     (wr_g),
        .wr_pfn0  (wr_pfn0),
        .wr_c0    (wr_c0),
        .wr_d0    (wr_d0),
        .wr_v0    (wr_v0),
        .wr_pfn1  (wr_pfn1),
        .wr_c1    (wr_c1),
        .wr_d1    (wr_d1),
        .wr_v1    (wr_v1),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_valid (rd_valid),
        .rd_vpn2  (rd_vpn2),
        .rd_asid  (rd_asid),
        .rd_g     (rd_g),
        .rd_pfn0  (rd_pfn0),
        .rd_c0    (rd_c0),
        .rd_d0    (rd_d0),
        .rd_v0    (rd_v0),
        .rd_pfn1  (rd_pfn1),
        .rd_c1    (rd_c1),
        .rd_d1    (rd_d1),
        .rd_v1    (rd_v1),
        .search   (search_if.array)
    );

endmodule

// ==== verif/mmu_tb.sv ====
`timescale 1ns/10ps

module mmu_tb;

    localparam int TLB_ENTRIES = 16;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);
    localparam int WAIT_LIMIT  = 200;

    logic             aclk = 1'b0;
    logic             rst;
    logic             req_valid, req_ready, req_store, rsp_valid, rsp_ready;
    logic [31:0]      req_vaddr, rsp_paddr;
    logic [7:0]       req_asid, wr_asid, rd_asid;
    logic [2:0]       rsp_cattr, wr_c0, wr_c1, rd_c0, rd_c1;
    logic [IDX_W-1:0] rsp_index, wr_index, rd_index;
    logic [1:0]       rsp_fault;
    logic [18:0]      wr_vpn2, rd_vpn2;
    logic [19:0]      wr_pfn0, wr_pfn1, rd_pfn0, rd_pfn1;
    logic             wr_en, wr_g, wr_d0, wr_v0, wr_d1, wr_v1;
    logic             rd_en, rd_valid, rd_g, rd_d0, rd_v0, rd_d1, rd_v1;

    integer           seed = 47;
    integer           fd;
    int               cycle = 0;
    int               issued = 0;
    int               received = 0;
    int               n;
    logic             stall_mode = 1'b0;
    logic [31:0]      f [12];
    string            line;
    string            name;
    byte              cmd;

    // expected responses in request order
    logic [79:0]      exp_q [$];
    string            name_q [$];
    int               accept_q [$];

    mmu_top #(.TLB_ENTRIES(TLB_ENTRIES)) mmu_top_i (.*);

    always #4 aclk = ~aclk;

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string test, input logic [79:0] expected,
                               input logic [79:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic require_fields(input int got, input int want);
        if (got != want) begin
            $display("malformed pattern line: %s", line);
            abort_run();
        end
    endtask

    // returns positioned just after a rising edge with the pipeline empty
    task automatic drain_responses();
        int waited = 0;
        do begin
            @(negedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("no response arrived within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
        end while (received != issued);
        @(posedge aclk);
    endtask

    task automatic write_entry();
        drain_responses();
        wr_en    <= 1'b1;
        wr_index <= f[0][IDX_W-1:0];
        wr_vpn2  <= f[1][18:0];
        wr_asid  <= f[2][7:0];
        wr_g     <= f[3][0];
        wr_pfn0  <= f[4][19:0];
        wr_c0    <= f[5][2:0];
        wr_d0    <= f[6][0];
        wr_v0    <= f[7][0];
        wr_pfn1  <= f[8][19:0];
        wr_c1    <= f[9][2:0];
        wr_d1    <= f[10][0];
        wr_v1    <= f[11][0];
        @(posedge aclk);
        wr_en <= 1'b0;
    endtask

    task automatic read_entry(input string test);
        int waited = 0;
        rd_en    <= 1'b1;
        rd_index <= f[0][IDX_W-1:0];
        @(posedge aclk);
        rd_en <= 1'b0;
        do begin
            @(negedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("read of entry %0d never returned rd_valid", f[0]);
                abort_run();
            end
        end while (!rd_valid);
        check_value({test, " read latency"}, 1, waited);
        check_value(test,
            {f[1][18:0], f[2][7:0], f[3][0], f[4][19:0], f[5][2:0], f[6][0], f[7][0],
             f[8][19:0], f[9][2:0], f[10][0], f[11][0]},
            {rd_vpn2, rd_asid, rd_g, rd_pfn0, rd_c0, rd_d0, rd_v0,
             rd_pfn1, rd_c1, rd_d1, rd_v1});
        @(negedge aclk);
        check_value({test, " rd_valid pulse"}, 0, rd_valid);
        @(posedge aclk);
    endtask

    // leaves req_valid high so a following request goes out back to back
    task automatic translate(input string test);
        int waited = 0;
        req_valid <= 1'b1;
        req_vaddr <= f[0];
        req_asid  <= f[1][7:0];
        req_store <= f[2][0];
        exp_q.push_back({f[3], f[4][2:0], f[5][IDX_W-1:0], f[6][1:0]});
        name_q.push_back(test);
        issued++;
        do begin
            @(posedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("request %s was not accepted within %0d cycles", test, WAIT_LIMIT);
                abort_run();
            end
        end while (!req_ready);
    endtask

    // response side, random rsp_ready stalls when enabled
    always @(posedge aclk) begin
        int lat;
        rsp_ready <= stall_mode ? (($random(seed) & 3) != 0) : 1'b1;
        if (!rst && rsp_valid && rsp_ready) begin
            if (accept_q.size() == 0) begin
                $display("response arrived with no request outstanding");
                abort_run();
            end
            lat = cycle - accept_q.pop_front();
            if (!stall_mode) begin
                check_value({name_q[0], " latency"}, 2, lat);
            end
            check_value(name_q.pop_front(), exp_q.pop_front(),
                        {rsp_paddr, rsp_cattr, rsp_index, rsp_fault});
            received++;
        end
        if (!rst && req_valid && req_ready) begin
            accept_q.push_back(cycle);
        end
        cycle++;
    end

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_asid  = '0;
        req_store = 1'b0;
        rsp_ready = 1'b1;
        wr_en     = 1'b0;
        wr_index  = '0;
        {wr_vpn2, wr_asid, wr_g, wr_pfn0, wr_c0, wr_d0, wr_v0} = '0;
        {wr_pfn1, wr_c1, wr_d1, wr_v1} = '0;
        rd_en     = 1'b0;
        rd_index  = '0;
        repeat (7) @(posedge aclk);
        @(negedge aclk);
        check_value("outputs in reset", 0, {req_ready, rsp_valid, rd_valid});
        @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);
        @(negedge aclk);
        check_value("req_ready after reset", 1, req_ready);
        @(posedge aclk);

        fd = $fopen("verif/mmu_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/mmu_patterns.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            cmd = line.getc(0);
            if (cmd == "W" || cmd == "R" || cmd == "S") begin
                req_valid <= 1'b0;
            end
            case (cmd)
                "W": begin
                    n = $sscanf(line, "W %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
                    require_fields(n, 12);
                    write_entry();
                end
                "R": begin
                    n = $sscanf(line, "R %h %h %h %h %h %h %h %h %h %h %h %h %s", f[0], f[1],
                                f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                                name);
                    require_fields(n, 13);
                    read_entry(name);
                end
                "T": begin
                    n = $sscanf(line, "T %h %h %h %h %h %h %h %s", f[0], f[1], f[2], f[3],
                                f[4], f[5], f[6], name);
                    require_fields(n, 8);
                    translate(name);
                end
                "S": begin
                    n = $sscanf(line, "S %h", f[0]);
                    require_fields(n, 1);
                    drain_responses();
                    stall_mode <= f[0][0];
                end
                "#", "\n", " ": ;
                default: begin
                    $display("unknown pattern command: %s", line);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);
        req_valid <= 1'b0;
        drain_responses();
        // a duplicated response would still be in flight here
        @(negedge aclk);
        check_value("no response after the last one", 0, rsp_valid);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== verif/mmu_patterns.txt ====
# W idx vpn2 asid g pfn0 c0 d0 v0 pfn1 c1 d1 v1 / R same fields then name
# T vaddr asid store paddr cattr index fault name / S stall, all values hex
T 80001234 00 0 00001234 3 0 0 unmapped_empty
T bfc00000 05 1 1fc00000 3 0 0 unmapped_store
T c0001000 01 0 00000000 0 0 1 empty_refill
W 0 00010 05 0 12345 3 1 1 0abcd 2 1 1
W 5 00300 07 1 00777 1 1 1 00888 0 1 0
W 9 01234 05 0 55555 3 0 1 66666 3 1 1
R 0 00010 05 0 12345 3 1 1 0abcd 2 1 1 read_e0
R 5 00300 07 1 00777 1 1 1 00888 0 1 0 read_e5
R 9 01234 05 0 55555 3 0 1 66666 3 1 1 read_e9
# hits, asid rules and faults, issued back to back
T 00020123 05 0 12345123 3 0 0 even_hit
T 00021456 05 0 0abcd456 2 0 0 odd_hit
T 00020123 06 0 00000000 0 0 1 asid_refill
T 00100000 05 0 00000000 0 0 1 vpn2_refill
T 00600abc 33 0 00777abc 1 5 0 global_any_asid
T 00600abc 07 1 00777abc 1 5 0 global_store
T 00601abc 07 0 00000000 0 0 2 odd_invalid
T 02468010 05 1 00000000 0 0 3 store_modified
T 02468010 05 0 55555010 3 9 0 load_clean
T 02469ff0 05 1 66666ff0 3 9 0 store_dirty
# overwrite two entries
W 0 00010 05 0 0fedc 4 1 1 00000 0 0 0
W 5 00400 07 0 00999 2 1 1 00aaa 2 1 1
R 5 00400 07 0 00999 2 1 1 00aaa 2 1 1 read_e5_new
T 00020123 05 0 0fedc123 4 0 0 rewrite_even
T 00021456 05 0 00000000 0 0 2 rewrite_odd_invalid
T 00600abc 33 0 00000000 0 0 1 old_global_gone
T 00800abc 07 0 00999abc 2 5 0 new_entry_hit
T 00801abc 08 0 00000000 0 0 1 new_entry_asid
# random rsp_ready stalls
S 1
T 00020004 05 0 0fedc004 4 0 0 stall_0
T 80000010 00 0 00000010 3 0 0 stall_1
T 00800ff8 07 1 00999ff8 2 5 0 stall_2
T 02468ffc 05 0 55555ffc 3 9 0 stall_3
T 00801100 07 0 00aaa100 2 5 0 stall_4
T 00100000 05 0 00000000 0 0 1 stall_5
T 02469000 05 1 66666000 3 9 0 stall_6
T a0000100 00 0 00000100 3 0 0 stall_7
T 00021000 05 1 00000000 0 0 2 stall_8
T 02468020 05 1 00000000 0 0 3 stall_9
S 0
T 9ffffff0 12 0 1ffffff0 3 0 0 after_stall

// ==== files.f ====
source/mmu_pkg.sv
source/tlb_search_if.sv
source/tlb_array.sv
source/tlb_lookup.sv
source/mmu_top.sv
verif/mmu_tb.sv

// ==== Bender.yml ====
package:
  name: mmu

sources:
  - target: rtl
    files:
      - source/mmu_pkg.sv
      - source/tlb_search_if.sv
      - source/tlb_array.sv
      - source/tlb_lookup.sv
      - source/mmu_top.sv

  - target: verif
    files:
      - verif/mmu_tb.sv

# mmu_top is the rtl top level, mmu_tb the simulation top
# pattern data is read from verif/mmu_patterns.txt at run time
